// File: core_types_pkg.sv
// core sizes and the ALU reg-immediate opcode shared by the issue queue,
// the physical register file and the ALU pipe
package core_types_pkg;

    // data path
    localparam int XLEN = 32;

    // physical registers
    // the low tag bits pick the bank, the rest pick the row
    localparam int PR_COUNT = 64;
    localparam int LOG_PR_COUNT = $clog2(PR_COUNT);
    localparam int PRF_BANK_COUNT = 2;
    localparam int LOG_PRF_BANK_COUNT = $clog2(PRF_BANK_COUNT);

    // reorder buffer
    localparam int ROB_ENTRIES = 32;
    localparam int LOG_ROB_ENTRIES = $clog2(ROB_ENTRIES);

    // reg-imm ops, funct3 in the low bits, bit 3 marks the arithmetic shift
    typedef enum logic [3:0] {
        ADDI  = 4'b0000,
        SLLI  = 4'b0001,
        SLTI  = 4'b0010,
        SLTIU = 4'b0011,
        XORI  = 4'b0100,
        SRLI  = 4'b0101,
        ORI   = 4'b0110,
        ANDI  = 4'b0111,
        SRAI  = 4'b1101
    } alu_imm_op_e;

endpackage

// File: pe_lsb.sv
// priority encoder granting the lowest set request
// ack_mask marks the granted position and every position above it
module pe_lsb #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0] req_vec,
    output logic [WIDTH-1:0] ack_one_hot,
    output logic [WIDTH-1:0] ack_mask
);

    // two's complement isolates the lowest set bit
    assign ack_one_hot = req_vec & (~req_vec + WIDTH'(1));

    // bits below the grant cleared, zero stays zero
    assign ack_mask = ~(ack_one_hot - WIDTH'(1));

    always_comb begin
        assert ($onehot0(ack_one_hot) && ((ack_one_hot & ~req_vec) == '0))
            else $error("pe_lsb grant is not a single requested position");
    end

endmodule

// File: alu_imm_iq.sv
// issue queue for reg-imm ALU ops
// entries compact toward index 0 so index order is age order; the oldest
// ready entry issues to the ALU pipe and sends its register read request
module alu_imm_iq #(
    parameter int ALU_IMM_IQ_ENTRIES = 12,
    localparam int BANK_W = core_types_pkg::LOG_PRF_BANK_COUNT,
    localparam int UPPER_W = core_types_pkg::LOG_PR_COUNT - BANK_W
) (
    input  logic CLK,
    input  logic nRST,

    // enqueue
    input  logic                                        iq_enq_valid,
    input  core_types_pkg::alu_imm_op_e                 iq_enq_op,
    input  logic [11:0]                                 iq_enq_imm12,
    input  logic [core_types_pkg::LOG_PR_COUNT-1:0]     iq_enq_A_PR,
    input  logic                                        iq_enq_A_ready,
    input  logic                                        iq_enq_A_is_zero,
    input  logic [core_types_pkg::LOG_PR_COUNT-1:0]     iq_enq_dest_PR,
    input  logic [core_types_pkg::LOG_ROB_ENTRIES-1:0]  iq_enq_ROB_index,
    output logic                                        iq_enq_ready,

    // writeback bus
    input  logic [core_types_pkg::PRF_BANK_COUNT-1:0]              WB_bus_valid_by_bank,
    input  logic [core_types_pkg::PRF_BANK_COUNT-1:0][UPPER_W-1:0] WB_bus_upper_PR_by_bank,

    // issue to ALU pipe
    output logic                                        issue_valid,
    output core_types_pkg::alu_imm_op_e                 issue_op,
    output logic [11:0]                                 issue_imm12,
    output logic                                        issue_A_is_reg,
    output logic                                        issue_A_is_bus_forward,
    output logic [BANK_W-1:0]                           issue_A_bank,
    output logic [core_types_pkg::LOG_PR_COUNT-1:0]     issue_dest_PR,
    output logic [core_types_pkg::LOG_ROB_ENTRIES-1:0]  issue_ROB_index,
    input  logic                                        issue_ready,

    // register read request
    output logic                                        PRF_req_A_valid,
    output logic [core_types_pkg::LOG_PR_COUNT-1:0]     PRF_req_A_PR
);

    localparam int N = ALU_IMM_IQ_ENTRIES;
    localparam int IDX_W = $clog2(N + 1);

    // ------------------------------------------------------------------------
    // entry state

    logic [N-1:0]                                   valid_by_entry;
    core_types_pkg::alu_imm_op_e                    op_by_entry [N];
    logic [11:0]                                    imm12_by_entry [N];
    logic [core_types_pkg::LOG_PR_COUNT-1:0]        A_PR_by_entry [N];
    logic [N-1:0]                                   A_ready_by_entry;
    logic [N-1:0]                                   A_is_zero_by_entry;
    logic [core_types_pkg::LOG_PR_COUNT-1:0]        dest_PR_by_entry [N];
    logic [core_types_pkg::LOG_ROB_ENTRIES-1:0]     ROB_index_by_entry [N];

    logic [N-1:0] A_fwd_by_entry;
    logic [N-1:0] req_by_entry;
    logic [N-1:0] issue_one_hot;
    logic [N-1:0] issue_mask;
    logic [N-1:0] free_one_hot;
    logic [N-1:0] free_mask;
    logic [N-1:0] enq_one_hot;
    logic [N-1:0] shift_mask;
    logic [N:0]   valid_ext;
    logic [N:0]   enq_ext;
    logic [N-1:0] src_valid;
    logic [N-1:0] src_enq;
    logic [IDX_W-1:0] src_idx [N];
    logic         enq_fwd;
    logic         sel_fwd;
    logic         sel_zero;
    logic [core_types_pkg::LOG_PR_COUNT-1:0] sel_A_PR;

    // tag seen on its bank's writeback slot this cycle
    function automatic logic bus_hit(input logic [core_types_pkg::LOG_PR_COUNT-1:0] tag);
        logic [BANK_W-1:0] bank;
        bank = tag[BANK_W-1:0];
        return WB_bus_valid_by_bank[bank]
            && (WB_bus_upper_PR_by_bank[bank] == tag[core_types_pkg::LOG_PR_COUNT-1:BANK_W]);
    endfunction

    always_comb begin
        for (int i = 0; i < N; i++) begin
            A_fwd_by_entry[i] = bus_hit(A_PR_by_entry[i]);
        end
    end

    assign enq_fwd = bus_hit(iq_enq_A_PR);

    // ------------------------------------------------------------------------
    // issue select

    assign req_by_entry = valid_by_entry
        & (A_ready_by_entry | A_fwd_by_entry | A_is_zero_by_entry);

    pe_lsb #(.WIDTH(N)) issue_pe (
        .req_vec    (req_by_entry),
        .ack_one_hot(issue_one_hot),
        .ack_mask   (issue_mask)
    );

    // one-hot mux of the winning entry
    always_comb begin
        issue_op = core_types_pkg::ADDI;
        issue_imm12 = '0;
        issue_dest_PR = '0;
        issue_ROB_index = '0;
        sel_A_PR = '0;
        sel_fwd = 1'b0;
        sel_zero = 1'b0;
        for (int i = 0; i < N; i++) begin
            if (issue_one_hot[i]) begin
                issue_op = op_by_entry[i];
                issue_imm12 = imm12_by_entry[i];
                issue_dest_PR = dest_PR_by_entry[i];
                issue_ROB_index = ROB_index_by_entry[i];
                sel_A_PR = A_PR_by_entry[i];
                sel_fwd = A_fwd_by_entry[i];
                sel_zero = A_is_zero_by_entry[i];
            end
        end
    end

    assign issue_valid = |req_by_entry;
    assign issue_A_is_bus_forward = sel_fwd & ~sel_zero;
    assign issue_A_is_reg = ~sel_fwd & ~sel_zero;
    assign issue_A_bank = sel_A_PR[BANK_W-1:0];
    assign PRF_req_A_valid = issue_valid & issue_ready & issue_A_is_reg;
    assign PRF_req_A_PR = sel_A_PR;

    // ------------------------------------------------------------------------
    // enqueue and compaction

    pe_lsb #(.WIDTH(N)) free_pe (
        .req_vec    (~valid_by_entry),
        .ack_one_hot(free_one_hot),
        .ack_mask   (free_mask)
    );

    // top mask bit is set whenever any slot is free
    assign iq_enq_ready = free_mask[N-1];
    assign enq_one_hot = free_one_hot & {N{iq_enq_valid}};

    // issued entry and all above it pull down by one
    assign shift_mask = issue_mask & {N{issue_ready}};
    assign valid_ext = {1'b0, valid_by_entry};
    assign enq_ext = {1'b0, enq_one_hot};

    always_comb begin
        for (int i = 0; i < N; i++) begin
            src_idx[i] = IDX_W'(i + int'(shift_mask[i]));
            src_valid[i] = valid_ext[i + int'(shift_mask[i])];
            src_enq[i] = enq_ext[i + int'(shift_mask[i])];
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_by_entry <= '0;
        end else begin
            valid_by_entry <= src_valid | src_enq;
        end
    end

    always_ff @(posedge CLK) begin
        for (int i = 0; i < N; i++) begin
            if (src_valid[i]) begin
                op_by_entry[i] <= op_by_entry[src_idx[i]];
                imm12_by_entry[i] <= imm12_by_entry[src_idx[i]];
                A_PR_by_entry[i] <= A_PR_by_entry[src_idx[i]];
                A_ready_by_entry[i] <= A_ready_by_entry[src_idx[i]] | A_fwd_by_entry[src_idx[i]];
                A_is_zero_by_entry[i] <= A_is_zero_by_entry[src_idx[i]];
                dest_PR_by_entry[i] <= dest_PR_by_entry[src_idx[i]];
                ROB_index_by_entry[i] <= ROB_index_by_entry[src_idx[i]];
            end else begin
                op_by_entry[i] <= iq_enq_op;
                imm12_by_entry[i] <= iq_enq_imm12;
                A_PR_by_entry[i] <= iq_enq_A_PR;
                A_ready_by_entry[i] <= iq_enq_A_ready | enq_fwd;
                A_is_zero_by_entry[i] <= iq_enq_A_is_zero;
                dest_PR_by_entry[i] <= iq_enq_dest_PR;
                ROB_index_by_entry[i] <= iq_enq_ROB_index;
            end
        end
    end

    // an op offered with every slot taken would be lost
    assert property (@(posedge CLK) disable iff (!nRST) iq_enq_valid |-> iq_enq_ready)
        else $error("enqueue while issue queue full");

    // compaction keeps the oldest valid entry at index 0
    assert property (@(posedge CLK) disable iff (!nRST) issue_valid |-> valid_by_entry[0])
        else $error("issue_valid with no valid entry at the head");

endmodule

// File: prf_banked.sv
// two-bank physical register file
// one writeback per bank per cycle, registered read, tag 0 reads as zero
module prf_banked (
    input  logic CLK,
    input  logic nRST,

    input  logic [core_types_pkg::PRF_BANK_COUNT-1:0] WB_bus_valid_by_bank,
    input  logic [core_types_pkg::PRF_BANK_COUNT-1:0]
                 [core_types_pkg::LOG_PR_COUNT-core_types_pkg::LOG_PRF_BANK_COUNT-1:0]
                                                      WB_bus_upper_PR_by_bank,
    input  logic [core_types_pkg::PRF_BANK_COUNT-1:0][core_types_pkg::XLEN-1:0]
                                                      WB_bus_data_by_bank,

    input  logic                                      PRF_req_A_valid,
    input  logic [core_types_pkg::LOG_PR_COUNT-1:0]   PRF_req_A_PR,
    output logic [core_types_pkg::XLEN-1:0]           PRF_read_data
);

    localparam int BANKS = core_types_pkg::PRF_BANK_COUNT;
    localparam int ROWS = core_types_pkg::PR_COUNT / BANKS;
    localparam int BANK_W = core_types_pkg::LOG_PRF_BANK_COUNT;

    logic [core_types_pkg::XLEN-1:0] mem [BANKS][ROWS];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int b = 0; b < BANKS; b++) begin
                for (int r = 0; r < ROWS; r++) begin
                    mem[b][r] <= '0;
                end
            end
            PRF_read_data <= '0;
        end else begin
            for (int b = 0; b < BANKS; b++) begin
                if (WB_bus_valid_by_bank[b]) begin
                    mem[b][WB_bus_upper_PR_by_bank[b]] <= WB_bus_data_by_bank[b];
                end
            end
            // read sees the array before this edge's writes
            if (PRF_req_A_valid) begin
                PRF_read_data <= (PRF_req_A_PR == '0) ? '0 :
                    mem[PRF_req_A_PR[BANK_W-1:0]]
                       [PRF_req_A_PR[core_types_pkg::LOG_PR_COUNT-1:BANK_W]];
            end
        end
    end

endmodule

// File: alu_imm_pipe.sv
// two-stage reg-immediate ALU pipe: latch at issue, compute the next cycle
// and register the result; stall holds issue_ready low
module alu_imm_pipe (
    input  logic CLK,
    input  logic nRST,

    // issue from the queue
    input  logic                                        issue_valid,
    input  core_types_pkg::alu_imm_op_e                 issue_op,
    input  logic [11:0]                                 issue_imm12,
    input  logic                                        issue_A_is_reg,
    input  logic                                        issue_A_is_bus_forward,
    input  logic [core_types_pkg::LOG_PRF_BANK_COUNT-1:0] issue_A_bank,
    input  logic [core_types_pkg::LOG_PR_COUNT-1:0]     issue_dest_PR,
    input  logic [core_types_pkg::LOG_ROB_ENTRIES-1:0]  issue_ROB_index,
    output logic                                        issue_ready,
    input  logic                                        stall,

    // operand sources
    input  logic [core_types_pkg::PRF_BANK_COUNT-1:0]   WB_bus_valid_by_bank,
    input  logic [core_types_pkg::PRF_BANK_COUNT-1:0][core_types_pkg::XLEN-1:0]
                                                        WB_bus_data_by_bank,
    input  logic [core_types_pkg::XLEN-1:0]             PRF_read_data,

    // results
    output logic                                        result_valid,
    output core_types_pkg::alu_imm_op_e                 result_op,
    output logic [core_types_pkg::LOG_PR_COUNT-1:0]     result_dest_PR,
    output logic [core_types_pkg::LOG_ROB_ENTRIES-1:0]  result_ROB_index,
    output logic [core_types_pkg::XLEN-1:0]             result_data
);

    logic                                       fire;
    logic                                       ex_valid;
    core_types_pkg::alu_imm_op_e                ex_op;
    logic [11:0]                                ex_imm12;
    logic                                       ex_is_reg;
    logic                                       ex_is_fwd;
    logic [core_types_pkg::XLEN-1:0]            ex_fwd_data;
    logic [core_types_pkg::LOG_PR_COUNT-1:0]    ex_dest_PR;
    logic [core_types_pkg::LOG_ROB_ENTRIES-1:0] ex_ROB_index;
    logic [core_types_pkg::XLEN-1:0]            operand;
    logic [core_types_pkg::XLEN-1:0]            imm;
    logic [4:0]                                 shamt;
    logic [core_types_pkg::XLEN-1:0]            alu_out;

    // no back-pressure of its own
    assign issue_ready = ~stall;
    assign fire = issue_valid & issue_ready;

    // ------------------------------------------------------------------------
    // issue latch

    always_ff @(posedge CLK) begin
        if (fire) begin
            ex_op <= issue_op;
            ex_imm12 <= issue_imm12;
            ex_is_reg <= issue_A_is_reg;
            ex_is_fwd <= issue_A_is_bus_forward;
            ex_dest_PR <= issue_dest_PR;
            ex_ROB_index <= issue_ROB_index;
        end
        // bus value only lives this cycle
        if (fire && WB_bus_valid_by_bank[issue_A_bank]) begin
            ex_fwd_data <= WB_bus_data_by_bank[issue_A_bank];
        end
    end

    // ------------------------------------------------------------------------
    // execute

    assign operand = ex_is_reg ? PRF_read_data : (ex_is_fwd ? ex_fwd_data : '0);
    assign imm = {{(core_types_pkg::XLEN-12){ex_imm12[11]}}, ex_imm12};
    assign shamt = ex_imm12[4:0];

    always_comb begin
        alu_out = '0;
        case (ex_op)
            core_types_pkg::ADDI:  alu_out = operand + imm;
            core_types_pkg::SLLI:  alu_out = operand << shamt;
            core_types_pkg::SLTI:  alu_out[0] = $signed(operand) < $signed(imm);
            core_types_pkg::SLTIU: alu_out[0] = operand < imm;
            core_types_pkg::XORI:  alu_out = operand ^ imm;
            core_types_pkg::SRLI:  alu_out = operand >> shamt;
            core_types_pkg::ORI:   alu_out = operand | imm;
            core_types_pkg::ANDI:  alu_out = operand & imm;
            core_types_pkg::SRAI:  alu_out = $signed(operand) >>> shamt;
            default:               alu_out = '0;
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            ex_valid <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            ex_valid <= fire;
            result_valid <= ex_valid;
        end
    end

    always_ff @(posedge CLK) begin
        result_op <= ex_op;
        result_dest_PR <= ex_dest_PR;
        result_ROB_index <= ex_ROB_index;
        result_data <= alu_out;
    end

    // queue must pick exactly one operand source
    assert property (@(posedge CLK) disable iff (!nRST)
        fire |-> !(issue_A_is_reg && issue_A_is_bus_forward))
        else $error("operand both register and bus forward");

endmodule

// File: alu_imm_top.sv
// reg-immediate ALU corner: issue queue feeding the ALU pipe, with the
// banked register file supplying the operand
module alu_imm_top #(
    parameter int ALU_IMM_IQ_ENTRIES = 6
) (
    input  logic CLK,
    input  logic nRST,

    // enqueue
    input  logic                                        iq_enq_valid,
    input  core_types_pkg::alu_imm_op_e                 iq_enq_op,
    input  logic [11:0]                                 iq_enq_imm12,
    input  logic [core_types_pkg::LOG_PR_COUNT-1:0]     iq_enq_A_PR,
    input  logic                                        iq_enq_A_ready,
    input  logic                                        iq_enq_A_is_zero,
    input  logic [core_types_pkg::LOG_PR_COUNT-1:0]     iq_enq_dest_PR,
    input  logic [core_types_pkg::LOG_ROB_ENTRIES-1:0]  iq_enq_ROB_index,
    output logic                                        iq_enq_ready,

    // writeback bus from the rest of the core
    input  logic [core_types_pkg::PRF_BANK_COUNT-1:0]   WB_bus_valid_by_bank,
    input  logic [core_types_pkg::PRF_BANK_COUNT-1:0]
                 [core_types_pkg::LOG_PR_COUNT-core_types_pkg::LOG_PRF_BANK_COUNT-1:0]
                                                        WB_bus_upper_PR_by_bank,
    input  logic [core_types_pkg::PRF_BANK_COUNT-1:0][core_types_pkg::XLEN-1:0]
                                                        WB_bus_data_by_bank,
    input  logic                                        stall,

    // results
    output logic                                        result_valid,
    output core_types_pkg::alu_imm_op_e                 result_op,
    output logic [core_types_pkg::LOG_PR_COUNT-1:0]     result_dest_PR,
    output logic [core_types_pkg::LOG_ROB_ENTRIES-1:0]  result_ROB_index,
    output logic [core_types_pkg::XLEN-1:0]             result_data
);

    // queue to pipe
    logic                                         issue_valid;
    core_types_pkg::alu_imm_op_e                  issue_op;
    logic [11:0]                                  issue_imm12;
    logic                                         issue_A_is_reg;
    logic                                         issue_A_is_bus_forward;
    logic [core_types_pkg::LOG_PRF_BANK_COUNT-1:0] issue_A_bank;
    logic [core_types_pkg::LOG_PR_COUNT-1:0]      issue_dest_PR;
    logic [core_types_pkg::LOG_ROB_ENTRIES-1:0]   issue_ROB_index;
    logic                                         issue_ready;

    // register read
    logic                                         PRF_req_A_valid;
    logic [core_types_pkg::LOG_PR_COUNT-1:0]      PRF_req_A_PR;
    logic [core_types_pkg::XLEN-1:0]              PRF_read_data;

    alu_imm_iq #(.ALU_IMM_IQ_ENTRIES(ALU_IMM_IQ_ENTRIES)) iq (.*);

    prf_banked prf (.*);

    alu_imm_pipe pipe (.*);

endmodule

// File: tb_clock.sv
// clock and reset for the ALU corner testbench
// period 100, reset held low for the first 8 rising edges
module tb_clock (
    output logic CLK,
    output logic nRST
);
    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end
    initial begin
        nRST = 1'b0;
        repeat (8) @(posedge CLK);
        #10 nRST = 1'b1;
    end
endmodule

// File: alu_imm_tb.sv
// table-driven testbench for the reg-immediate ALU corner
// each step drives enqueue, one writeback and stall; a model of the
// queue rules predicts result order, timing and data
module alu_imm_tb;

    localparam int DEPTH = 6;

    typedef struct packed {
        logic [2:0] test;
        logic enq;
        core_types_pkg::alu_imm_op_e op;
        logic [11:0] imm;
        logic [5:0] src;
        logic rdy;
        logic zero;
        logic [5:0] dest;
        logic [4:0] rob;
        logic [1:0] wb_v;
        logic [1:0][4:0] wb_up;
        logic [1:0][31:0] wb_d;
        logic stall;
    } step_t;
    typedef struct packed {
        core_types_pkg::alu_imm_op_e op;
        logic [5:0] dest;
        logic [4:0] rob;
        logic [31:0] data;
        int due;
    } exp_t;

    logic CLK, nRST, iq_enq_valid, iq_enq_A_ready, iq_enq_A_is_zero, iq_enq_ready, stall;
    core_types_pkg::alu_imm_op_e iq_enq_op, result_op;
    logic [11:0] iq_enq_imm12;
    logic [5:0] iq_enq_A_PR, iq_enq_dest_PR, result_dest_PR;
    logic [4:0] iq_enq_ROB_index, result_ROB_index;
    logic [1:0] WB_bus_valid_by_bank;
    logic [1:0][4:0] WB_bus_upper_PR_by_bank;
    logic [1:0][31:0] WB_bus_data_by_bank;
    logic result_valid;
    logic [31:0] result_data;

    step_t steps[$];
    step_t pend[$];
    exp_t expq[$];
    logic [31:0] regs [64];
    logic [31:0] lfsr = 32'hab3da712;
    logic [4:0] rob_next = '0;
    int errors = 0, checks = 0, test_errors = 0, tests_failed = 0;
    int cycles = 0, limit = 1000000, cur_test = 2;
    string test_names [6] = '{"", "reset", "opcodes", "wake-up", "age order", "full queue"};
    core_types_pkg::alu_imm_op_e ops [9] = '{core_types_pkg::ADDI, core_types_pkg::SLLI,
        core_types_pkg::SLTI, core_types_pkg::SLTIU, core_types_pkg::XORI,
        core_types_pkg::SRLI, core_types_pkg::ORI, core_types_pkg::ANDI, core_types_pkg::SRAI};

    tb_clock clock_gen (.CLK(CLK), .nRST(nRST));
    alu_imm_top #(.ALU_IMM_IQ_ENTRIES(DEPTH)) dut (.*);

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] alu_ref(input core_types_pkg::alu_imm_op_e op,
                                            input logic [31:0] a, input logic [11:0] imm12);
        logic [31:0] imm;
        logic [63:0] sra;
        imm = {{20{imm12[11]}}, imm12};
        sra = {{32{a[31]}}, a} >> imm12[4:0];
        case (op)
            core_types_pkg::ADDI:  return a + imm;
            core_types_pkg::SLLI:  return a << imm12[4:0];
            core_types_pkg::SLTI:  return {31'b0, $signed(a) < $signed(imm)};
            core_types_pkg::SLTIU: return {31'b0, a < imm};
            core_types_pkg::XORI:  return a ^ imm;
            core_types_pkg::SRLI:  return a >> imm12[4:0];
            core_types_pkg::ORI:   return a | imm;
            core_types_pkg::ANDI:  return a & imm;
            default:               return sra[31:0];
        endcase
    endfunction

    function automatic logic on_bus(input step_t st, input logic [5:0] tag);
        return st.wb_v[tag[0]] && (st.wb_up[tag[0]] == tag[5:1]);
    endfunction

    // wtag of 0 means no writeback in this step
    task automatic add_step(input int test, input logic enq, input core_types_pkg::alu_imm_op_e op,
                            input logic [5:0] src, input logic rdy, input logic zero,
                            input logic [5:0] wtag, input logic stl);
        step_t st;
        st = '0;
        st.test = 3'(test);
        st.enq = enq;
        st.op = op;
        st.imm = take_bits(12);
        st.src = src;
        st.rdy = rdy;
        st.zero = zero;
        st.stall = stl;
        if (enq) begin
            st.rob = rob_next;
            st.dest = {1'b1, rob_next};
            rob_next++;
        end
        if (wtag != 0) begin
            st.wb_v[wtag[0]] = 1'b1;
            st.wb_up[wtag[0]] = wtag[5:1];
            st.wb_d[wtag[0]] = take_bits(32);
        end
        steps.push_back(st);
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %0t %s got %0h expected %0h", $time, name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("[FAIL] %0t %s", $time, what);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_test(input int t);
        $display("test %0d %s: %s", t, test_names[t], (test_errors == 0) ? "ok" : "FAILED");
        if (test_errors != 0) tests_failed++;
        test_errors = 0;
    endtask

    task automatic drive(input step_t st);
        iq_enq_valid = st.enq;
        iq_enq_op = st.op;
        iq_enq_imm12 = st.imm;
        iq_enq_A_PR = st.src;
        iq_enq_A_ready = st.rdy;
        iq_enq_A_is_zero = st.zero;
        iq_enq_dest_PR = st.dest;
        iq_enq_ROB_index = st.rob;
        WB_bus_valid_by_bank = st.wb_v;
        WB_bus_upper_PR_by_bank = st.wb_up;
        WB_bus_data_by_bank = st.wb_d;
        stall = st.stall;
    endtask

    // one cycle: check outputs of the last edge, drive, then advance the model
    task automatic run_step(input step_t st, input int s);
        int pick;
        logic [31:0] a;
        exp_t e;
        @(posedge CLK);
        #10;
        check_value("iq_enq_ready", iq_enq_ready, pend.size() < DEPTH);
        if (result_valid) begin
            check_true(expq.size() > 0, "result appeared with no op in flight");
            if (expq.size() > 0) begin
                check_value("result due step", s, expq[0].due);
                check_value("result_op", result_op, expq[0].op);
                check_value("result_dest_PR", result_dest_PR, expq[0].dest);
                check_value("result_ROB_index", result_ROB_index, expq[0].rob);
                check_value("result_data", result_data, expq[0].data);
                void'(expq.pop_front());
            end
        end else if (expq.size() > 0 && expq[0].due <= s) begin
            check_true(1'b0, $sformatf("result for ROB index %0d never arrived", expq[0].rob));
            void'(expq.pop_front());
        end
        drive(st);
        // oldest ready entry issues unless stalled
        pick = -1;
        for (int i = 0; i < pend.size(); i++) begin
            if (pick < 0 && !st.stall && (pend[i].rdy || pend[i].zero || on_bus(st, pend[i].src)))
                pick = i;
        end
        if (pick >= 0) begin
            if (pend[pick].zero) a = '0;
            else if (on_bus(st, pend[pick].src)) a = st.wb_d[pend[pick].src[0]];
            else a = regs[pend[pick].src];
            e.op = pend[pick].op;
            e.dest = pend[pick].dest;
            e.rob = pend[pick].rob;
            e.data = alu_ref(pend[pick].op, a, pend[pick].imm);
            e.due = s + 2;
            expq.push_back(e);
            pend.delete(pick);
        end
        for (int i = 0; i < pend.size(); i++) begin
            if (on_bus(st, pend[i].src)) pend[i].rdy = 1'b1;
        end
        for (int b = 0; b < 2; b++) begin
            if (st.wb_v[b]) regs[{st.wb_up[b], b[0]}] = st.wb_d[b];
        end
        if (st.enq) begin
            st.rdy = st.rdy | on_bus(st, st.src);
            pend.push_back(st);
        end
    endtask

    always @(posedge CLK) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles with results still outstanding", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        int s;
        for (int i = 0; i < 64; i++) regs[i] = '0;
        drive('0);
        // opcodes, registers 2 to 5 written first
        for (int t = 2; t <= 5; t++) add_step(2, 0, ops[0], 0, 0, 0, 6'(t), 0);
        for (int i = 0; i < 9; i++) add_step(2, 1, ops[i], 0, 0, 1, 0, 0);
        for (int i = 0; i < 9; i++) add_step(2, 1, ops[i], 6'(2 + i % 4), 1, 0, 0, 0);
        for (int i = 0; i < 3; i++) add_step(2, 0, ops[0], 0, 0, 0, 0, 0);
        // wake-up, last tag written under stall so it reads the register file
        add_step(3, 1, ops[0], 10, 0, 0, 0, 0);
        add_step(3, 1, ops[8], 13, 0, 0, 0, 0);
        add_step(3, 1, ops[4], 21, 0, 0, 0, 0);
        for (int i = 0; i < 3; i++) add_step(3, 0, ops[0], 0, 0, 0, 0, 0);
        add_step(3, 0, ops[0], 0, 0, 0, 10, 0);
        add_step(3, 0, ops[0], 0, 0, 0, 13, 0);
        add_step(3, 0, ops[0], 0, 0, 0, 21, 1);
        for (int i = 0; i < 3; i++) add_step(3, 0, ops[0], 0, 0, 0, 0, 0);
        // age order
        for (int i = 0; i < 4; i++)
            add_step(4, 1, ops[i + 4], (i == 2) ? 6'd0 : 6'(2 + i), 1, i == 2, 0, 1);
        for (int i = 0; i < 4; i++) add_step(4, 0, ops[0], 0, 0, 0, 0, 0);
        // full queue
        for (int i = 0; i < DEPTH; i++) add_step(5, 1, ops[i], 6'(3 + i % 3), 1, 0, 0, 1);
        add_step(5, 0, ops[0], 0, 0, 0, 0, 1);
        add_step(5, 0, ops[0], 0, 0, 0, 0, 0);
        add_step(5, 1, ops[2], 5, 1, 0, 0, 0);
        for (int i = 0; i < 4; i++) add_step(5, 0, ops[0], 0, 0, 0, 0, 0);
        limit = steps.size() * 4 + 50;

        @(posedge nRST);
        @(posedge CLK);
        #10;
        check_value("issue_valid", dut.issue_valid, 1'b0);
        check_value("result_valid", result_valid, 1'b0);
        check_value("iq_enq_ready", iq_enq_ready, 1'b1);
        report_test(1);
        s = 0;
        foreach (steps[k]) begin
            if (steps[k].test != cur_test) begin
                report_test(cur_test);
                cur_test = steps[k].test;
            end
            run_step(steps[k], s);
            s++;
        end
        while (pend.size() > 0 || expq.size() > 0) begin
            run_step('0, s);
            s++;
        end
        report_test(cur_test);
        $display("tests 5, failed %0d, checks %0d, errors %0d", tests_failed, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: alu_imm_top.f
core_types_pkg.sv
pe_lsb.sv
alu_imm_iq.sv
prf_banked.sv
alu_imm_pipe.sv
alu_imm_top.sv
tb_clock.sv
alu_imm_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the ALU corner testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module alu_imm_tb -f alu_imm_top.f -o alu_imm_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi
output=$(./obj_dir/alu_imm_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if echo "$output" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
